// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - design/isa_pkg.sv
  - design/core_pkg.sv
  - design/decode_unit.sv
  - design/execute_unit.sv
  - design/result_stage.sv
  - design/rv_core.sv
  - target: simulation
    files:
      - verification/retire_checker.sv
      - verification/core_tb.sv

// ==== design/core_pkg.sv ====
package core_pkg;

	localparam int REG_ADDR_W = 5;

	// operation selected by decode, carried into execute
	typedef enum logic [3:0] {
		ADD,
		SUB,
		SLL,
		SLT,
		SLTU,
		XOR,
		SRL,
		SRA,
		OR,
		AND,
		PASS_B
	} alu_op_t;

	// source of alu operand b
	typedef enum logic {
		REG,
		IMM
	} op_b_sel_t;

endpackage

// ==== design/decode_unit.sv ====
`timescale 1ns/100ps

module decode_unit
	import isa_pkg::*;
	import core_pkg::*;
#(
	parameter int XLEN = 32
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  inst_valid,
	input  logic [31:0]           inst,
	input  logic [XLEN-1:0]       rs1_data,
	input  logic [XLEN-1:0]       rs2_data,
	output logic [REG_ADDR_W-1:0] rs1_addr,
	output logic [REG_ADDR_W-1:0] rs2_addr,
	output logic                  d_valid,
	output logic [31:0]           d_inst,
	output alu_op_t               d_alu_op,
	output op_b_sel_t             d_op_b_sel,
	output logic [XLEN-1:0]       d_imm,
	output logic [REG_ADDR_W-1:0] d_rs1_addr,
	output logic [REG_ADDR_W-1:0] d_rs2_addr,
	output logic [XLEN-1:0]       d_rs1_data,
	output logic [XLEN-1:0]       d_rs2_data,
	output logic                  d_rd_wena,
	output logic [REG_ADDR_W-1:0] d_rd_addr,
	output logic                  d_illegal
);

	inst_t     word;
	alu_op_t   alu_op;
	op_b_sel_t op_b_sel;
	logic [XLEN-1:0] imm;
	logic illegal;
	logic f7_zero;
	logic f7_alt;
	logic sh_zero;
	logic sh_alt;
	logic sh_bit5;

	assign word = inst_t'(inst);

	// source reads go straight to the register file
	assign rs1_addr = word.r_fmt.rs1;
	assign rs2_addr = word.r_fmt.rs2;

	assign f7_zero = word.r_fmt.funct7 == 7'b0;
	assign f7_alt  = word.r_fmt.funct7 == FUNCT7_ALT;

	// immediate shifts: imm12[11:6] is funct6, imm12[5] is shamt bit 5
	assign sh_zero = word.i_fmt.imm12[11:6] == 6'b0;
	assign sh_alt  = word.i_fmt.imm12[11:6] == FUNCT7_ALT[6:1];
	assign sh_bit5 = word.i_fmt.imm12[5] && (XLEN == 32);

	always_comb begin
		alu_op = ADD;
		op_b_sel = REG;
		imm = '0;
		illegal = 1'b0;
		case (word.r_fmt.opcode)
			OP_REG: begin
				case (word.r_fmt.funct3)
					F3_ADD_SUB: alu_op = f7_alt ? SUB : ADD;
					F3_SLL:     alu_op = SLL;
					F3_SLT:     alu_op = SLT;
					F3_SLTU:    alu_op = SLTU;
					F3_XOR:     alu_op = XOR;
					F3_SRL_SRA: alu_op = f7_alt ? SRA : SRL;
					F3_OR:      alu_op = OR;
					F3_AND:     alu_op = AND;
				endcase
				// alt funct7 only valid for sub and sra
				illegal = !(f7_zero || (f7_alt && (word.r_fmt.funct3 == F3_ADD_SUB ||
					word.r_fmt.funct3 == F3_SRL_SRA)));
			end
			OP_IMM: begin
				op_b_sel = IMM;
				imm = XLEN'($signed(word.i_fmt.imm12));
				case (word.i_fmt.funct3)
					F3_ADD_SUB: alu_op = ADD;
					F3_SLL: begin
						alu_op = SLL;
						illegal = !sh_zero || sh_bit5;
					end
					F3_SLT:  alu_op = SLT;
					F3_SLTU: alu_op = SLTU;
					F3_XOR:  alu_op = XOR;
					F3_SRL_SRA: begin
						alu_op = sh_alt ? SRA : SRL;
						illegal = !(sh_zero || sh_alt) || sh_bit5;
					end
					F3_OR:  alu_op = OR;
					F3_AND: alu_op = AND;
				endcase
			end
			OP_LUI: begin
				alu_op = PASS_B;
				op_b_sel = IMM;
				// upper 20 bits of the word, low 12 zero
				imm = XLEN'($signed({word.i_fmt.imm12, word.i_fmt.rs1, word.i_fmt.funct3,
					12'b0}));
			end
			default: illegal = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			d_valid <= 1'b0;
			d_rd_wena <= 1'b0;
			d_illegal <= 1'b0;
		end else begin
			d_valid <= inst_valid;
			d_rd_wena <= inst_valid && !illegal && word.r_fmt.rd != '0;
			d_illegal <= inst_valid && illegal;
		end
	end

	always_ff @(posedge clk) begin
		d_inst <= inst;
		d_alu_op <= alu_op;
		d_op_b_sel <= op_b_sel;
		d_imm <= imm;
		d_rs1_addr <= word.r_fmt.rs1;
		d_rs2_addr <= word.r_fmt.rs2;
		d_rs1_data <= rs1_data;
		d_rs2_data <= rs2_data;
		d_rd_addr <= word.r_fmt.rd;
	end

	// a valid word must be fully known
	assert property (@(posedge clk) disable iff (rst) inst_valid |-> !$isunknown(inst));

endmodule

// ==== design/execute_unit.sv ====
`timescale 1ns/100ps

module execute_unit
	import core_pkg::*;
#(
	parameter int XLEN = 32
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  d_valid,
	input  logic [31:0]           d_inst,
	input  alu_op_t               d_alu_op,
	input  op_b_sel_t             d_op_b_sel,
	input  logic [XLEN-1:0]       d_imm,
	input  logic [REG_ADDR_W-1:0] d_rs1_addr,
	input  logic [REG_ADDR_W-1:0] d_rs2_addr,
	input  logic [XLEN-1:0]       d_rs1_data,
	input  logic [XLEN-1:0]       d_rs2_data,
	input  logic                  d_rd_wena,
	input  logic [REG_ADDR_W-1:0] d_rd_addr,
	input  logic                  d_illegal,
	output logic                  e_valid,
	output logic [31:0]           e_inst,
	output logic                  e_illegal,
	output logic                  e_rd_wena,
	output logic [REG_ADDR_W-1:0] e_rd_addr,
	output logic [XLEN-1:0]       e_result
);

	localparam int SHAMT_W = (XLEN == 64) ? 6 : 5;

	logic fwd_rs1;
	logic fwd_rs2;
	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] rs2_val;
	logic [XLEN-1:0] op_b;
	logic [SHAMT_W-1:0] shamt;
	logic [XLEN-1:0] alu_result;

	// previous result not yet in the register file
	assign fwd_rs1 = e_valid && e_rd_wena && e_rd_addr == d_rs1_addr && e_rd_addr != '0;
	assign fwd_rs2 = e_valid && e_rd_wena && e_rd_addr == d_rs2_addr && e_rd_addr != '0;

	assign op_a    = fwd_rs1 ? e_result : d_rs1_data;
	assign rs2_val = fwd_rs2 ? e_result : d_rs2_data;
	assign op_b    = (d_op_b_sel == IMM) ? d_imm : rs2_val;
	assign shamt   = op_b[SHAMT_W-1:0];

	always_comb begin
		case (d_alu_op)
			ADD:     alu_result = op_a + op_b;
			SUB:     alu_result = op_a - op_b;
			SLL:     alu_result = op_a << shamt;
			SLT:     alu_result = XLEN'($signed(op_a) < $signed(op_b));
			SLTU:    alu_result = XLEN'(op_a < op_b);
			XOR:     alu_result = op_a ^ op_b;
			SRL:     alu_result = op_a >> shamt;
			SRA:     alu_result = $signed(op_a) >>> shamt;
			OR:      alu_result = op_a | op_b;
			AND:     alu_result = op_a & op_b;
			// lui
			PASS_B:  alu_result = op_b;
			default: alu_result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			e_valid <= 1'b0;
			e_rd_wena <= 1'b0;
			e_illegal <= 1'b0;
		end else begin
			e_valid <= d_valid;
			e_rd_wena <= d_valid && d_rd_wena;
			e_illegal <= d_valid && d_illegal;
		end
	end

	always_ff @(posedge clk) begin
		e_inst <= d_inst;
		e_rd_addr <= d_rd_addr;
		e_result <= alu_result;
	end

	assert property (@(posedge clk) disable iff (rst) !$isunknown(e_valid));

endmodule

// ==== design/isa_pkg.sv ====
package isa_pkg;

	// major opcodes
	localparam logic [6:0] OP_REG = 7'b0110011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_LUI = 7'b0110111;

	// funct3 field, shared by register and immediate forms
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// bit 30 set, picks sub and sra
	localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	// same 32-bit word seen as R-type or I-type
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
	} inst_t;

endpackage

// ==== design/result_stage.sv ====
`timescale 1ns/100ps

module result_stage
	import core_pkg::*;
#(
	parameter int XLEN = 32
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [REG_ADDR_W-1:0] rs1_addr,
	input  logic [REG_ADDR_W-1:0] rs2_addr,
	input  logic                  e_valid,
	input  logic [31:0]           e_inst,
	input  logic                  e_illegal,
	input  logic                  e_rd_wena,
	input  logic [REG_ADDR_W-1:0] e_rd_addr,
	input  logic [XLEN-1:0]       e_result,
	output logic [XLEN-1:0]       rs1_data,
	output logic [XLEN-1:0]       rs2_data,
	output logic                  retire_valid,
	output logic [31:0]           retire_inst,
	output logic                  retire_illegal,
	output logic                  retire_rd_wena,
	output logic [REG_ADDR_W-1:0] retire_rd_addr,
	output logic [XLEN-1:0]       retire_rd_data
);

	// x0 is not stored
	logic [XLEN-1:0] regs [1:31];
	logic wr_en;

	assign wr_en = e_valid && e_rd_wena;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[e_rd_addr] <= e_result;
		end
	end

	// write-through so decode sees the value landing at the next edge
	function automatic logic [XLEN-1:0] read_reg(input logic [REG_ADDR_W-1:0] addr);
		if (addr == '0) begin
			return '0;
		end
		if (wr_en && addr == e_rd_addr) begin
			return e_result;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rs1_data = read_reg(rs1_addr);
		rs2_data = read_reg(rs2_addr);
	end

	// retire reports the instruction being written back this cycle
	assign retire_valid   = e_valid;
	assign retire_inst    = e_inst;
	assign retire_illegal = e_illegal;
	assign retire_rd_wena = e_rd_wena;
	assign retire_rd_addr = e_rd_addr;
	assign retire_rd_data = e_result;

	// decode must have dropped the write enable for rd x0
	assert property (@(posedge clk) disable iff (rst) wr_en |-> e_rd_addr != '0);

endmodule

// ==== design/rv_core.sv ====
`timescale 1ns/100ps

module rv_core
	import core_pkg::*;
#(
	parameter int XLEN = 32
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            inst_valid,
	input  logic [31:0]     inst,
	output logic            retire_valid,
	output logic            retire_illegal,
	output logic            retire_rd_wena,
	output logic [31:0]     retire_inst,
	output logic [4:0]      retire_rd_addr,
	output logic [XLEN-1:0] retire_rd_data
);

	// register file read ports
	logic [REG_ADDR_W-1:0] rs1_addr;
	logic [REG_ADDR_W-1:0] rs2_addr;
	logic [XLEN-1:0]       rs1_data;
	logic [XLEN-1:0]       rs2_data;

	// decode -> execute
	logic                  d_valid;
	logic [31:0]           d_inst;
	alu_op_t               d_alu_op;
	op_b_sel_t             d_op_b_sel;
	logic [XLEN-1:0]       d_imm;
	logic [REG_ADDR_W-1:0] d_rs1_addr;
	logic [REG_ADDR_W-1:0] d_rs2_addr;
	logic [XLEN-1:0]       d_rs1_data;
	logic [XLEN-1:0]       d_rs2_data;
	logic                  d_rd_wena;
	logic [REG_ADDR_W-1:0] d_rd_addr;
	logic                  d_illegal;

	// execute -> result
	logic                  e_valid;
	logic [31:0]           e_inst;
	logic                  e_illegal;
	logic                  e_rd_wena;
	logic [REG_ADDR_W-1:0] e_rd_addr;
	logic [XLEN-1:0]       e_result;

	decode_unit #(
		.XLEN(XLEN)
	) decode_unit_i (
		.clk(clk),
		.rst(rst),
		.inst_valid(inst_valid),
		.inst(inst),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.d_valid(d_valid),
		.d_inst(d_inst),
		.d_alu_op(d_alu_op),
		.d_op_b_sel(d_op_b_sel),
		.d_imm(d_imm),
		.d_rs1_addr(d_rs1_addr),
		.d_rs2_addr(d_rs2_addr),
		.d_rs1_data(d_rs1_data),
		.d_rs2_data(d_rs2_data),
		.d_rd_wena(d_rd_wena),
		.d_rd_addr(d_rd_addr),
		.d_illegal(d_illegal)
	);

	execute_unit #(
		.XLEN(XLEN)
	) execute_unit_i (
		.clk(clk),
		.rst(rst),
		.d_valid(d_valid),
		.d_inst(d_inst),
		.d_alu_op(d_alu_op),
		.d_op_b_sel(d_op_b_sel),
		.d_imm(d_imm),
		.d_rs1_addr(d_rs1_addr),
		.d_rs2_addr(d_rs2_addr),
		.d_rs1_data(d_rs1_data),
		.d_rs2_data(d_rs2_data),
		.d_rd_wena(d_rd_wena),
		.d_rd_addr(d_rd_addr),
		.d_illegal(d_illegal),
		.e_valid(e_valid),
		.e_inst(e_inst),
		.e_illegal(e_illegal),
		.e_rd_wena(e_rd_wena),
		.e_rd_addr(e_rd_addr),
		.e_result(e_result)
	);

	result_stage #(
		.XLEN(XLEN)
	) result_stage_i (
		.clk(clk),
		.rst(rst),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.e_valid(e_valid),
		.e_inst(e_inst),
		.e_illegal(e_illegal),
		.e_rd_wena(e_rd_wena),
		.e_rd_addr(e_rd_addr),
		.e_result(e_result),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.retire_valid(retire_valid),
		.retire_inst(retire_inst),
		.retire_illegal(retire_illegal),
		.retire_rd_wena(retire_rd_wena),
		.retire_rd_addr(retire_rd_addr),
		.retire_rd_data(retire_rd_data)
	);

endmodule

// ==== sim.f ====
design/isa_pkg.sv
design/core_pkg.sv
design/decode_unit.sv
design/execute_unit.sv
design/result_stage.sv
design/rv_core.sv
verification/retire_checker.sv
verification/core_tb.sv

// ==== verification/core_tb.sv ====
`timescale 1ns/100ps

module core_tb
	import isa_pkg::*;
;

	localparam int XLEN = 32;
	localparam int NUM_INST = 2000;
	localparam int DRAIN_TIMEOUT = 100;

	logic clk;
	logic rst;
	logic inst_valid;
	logic [31:0] inst;
	logic retire_valid;
	logic retire_illegal;
	logic retire_rd_wena;
	logic [31:0] retire_inst;
	logic [4:0] retire_rd_addr;
	logic [XLEN-1:0] retire_rd_data;
	int err_count;
	int miss_count;
	int retire_count;
	int outstanding;
	int sent;
	int wait_cycles;
	logic timed_out;

	initial clk = 1'b0;
	always #2 clk = ~clk;

	rv_core #(
		.XLEN(XLEN)
	) rv_core_i (
		.clk(clk),
		.rst(rst),
		.inst_valid(inst_valid),
		.inst(inst),
		.retire_valid(retire_valid),
		.retire_illegal(retire_illegal),
		.retire_rd_wena(retire_rd_wena),
		.retire_inst(retire_inst),
		.retire_rd_addr(retire_rd_addr),
		.retire_rd_data(retire_rd_data)
	);

	retire_checker #(
		.XLEN(XLEN)
	) retire_checker_i (
		.clk(clk),
		.rst(rst),
		.inst_valid(inst_valid),
		.inst(inst),
		.retire_valid(retire_valid),
		.retire_inst(retire_inst),
		.retire_illegal(retire_illegal),
		.retire_rd_wena(retire_rd_wena),
		.retire_rd_addr(retire_rd_addr),
		.retire_rd_data(retire_rd_data),
		.err_count(err_count),
		.miss_count(miss_count),
		.retire_count(retire_count),
		.outstanding(outstanding)
	);

	// mostly x0..x7 so that dependencies are dense
	function automatic logic [4:0] pick_reg();
		if ($urandom_range(99) < 85)
			return 5'($urandom_range(7));
		return 5'($urandom_range(31));
	endfunction

	function automatic logic [31:0] random_inst();
		int kind;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [11:0] imm;
		kind = $urandom_range(99);
		rd = pick_reg();
		rs1 = pick_reg();
		rs2 = pick_reg();
		f3 = 3'($urandom_range(7));
		imm = 12'($urandom);
		f7 = ((f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) && $urandom_range(1)) ? FUNCT7_ALT : 7'b0;
		if (kind < 40)
			return {f7, rs2, rs1, f3, rd, OP_REG};
		if (kind < 75) begin
			if (f3 == F3_SLL || f3 == F3_SRL_SRA)
				imm = {f7[6:1], 1'b0, imm[4:0]};
			return {imm, rs1, f3, rd, OP_IMM};
		end
		if (kind < 87)
			return {20'($urandom), rd, OP_LUI};
		// illegal encodings from here on
		if (kind < 91)
			return {imm, rs1, f3, rd, 7'b0001011};
		if (kind < 95)
			return {7'b0000001, rs2, rs1, f3, rd, OP_REG};
		f3 = $urandom_range(1) ? F3_SLL : F3_SRL_SRA;
		return {f7[6:1], 1'b1, imm[4:0], rs1, f3, rd, OP_IMM};
	endfunction

	initial begin
		void'($urandom(32'h35c957a9));
		rst = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		timed_out = 1'b0;
		sent = 0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		while (sent < NUM_INST) begin
			@(negedge clk);
			if ($urandom_range(99) < 20) begin
				inst_valid = 1'b0;
			end else begin
				inst_valid = 1'b1;
				inst = random_inst();
				sent++;
			end
		end
		@(negedge clk);
		inst_valid = 1'b0;
		wait_cycles = 0;
		while (outstanding != 0 && wait_cycles < DRAIN_TIMEOUT) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (outstanding != 0) begin
			$display("retirement stalled with %0d instructions still in flight", outstanding);
			timed_out = 1'b1;
		end
		// a few idle cycles to catch a stray retire
		repeat (3) @(negedge clk);
		if (retire_count != NUM_INST)
			$display("retired %0d instructions but %0d were sent", retire_count, NUM_INST);
		$display("sent %0d, retired %0d, value errors %0d, missing retires %0d",
			sent, retire_count, err_count, miss_count);
		if (err_count == 0 && miss_count == 0 && !timed_out && retire_count == NUM_INST) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== verification/retire_checker.sv ====
`timescale 1ns/100ps

module retire_checker
	import isa_pkg::*;
#(
	parameter int XLEN = 32
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            inst_valid,
	input  logic [31:0]     inst,
	input  logic            retire_valid,
	input  logic [31:0]     retire_inst,
	input  logic            retire_illegal,
	input  logic            retire_rd_wena,
	input  logic [4:0]      retire_rd_addr,
	input  logic [XLEN-1:0] retire_rd_data,
	output int              err_count,
	output int              miss_count,
	output int              retire_count,
	output int              outstanding
);

	logic [XLEN-1:0] model [32];
	logic [31:0] q_inst [$];
	int q_cycle [$];
	int cycle;
	logic [31:0] head_inst;
	int head_cycle;
	logic exp_ill;
	logic exp_wena;
	logic [XLEN-1:0] exp_res;

	function automatic logic [XLEN-1:0] alu_calc(input logic [2:0] f3, input logic alt,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		int sh;
		sh = (XLEN == 64) ? int'(b[5:0]) : int'(b[4:0]);
		case (f3)
			F3_ADD_SUB: return alt ? a - b : a + b;
			F3_SLL:     return a << sh;
			F3_SLT:     return ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
			F3_SLTU:    return (a < b) ? XLEN'(1) : '0;
			F3_XOR:     return a ^ b;
			F3_SRL_SRA: begin
				if (alt)
					return $signed(a) >>> sh;
				return a >> sh;
			end
			F3_OR:      return a | b;
			default:    return a & b;
		endcase
	endfunction

	// reference decode straight from the bit fields, operands from the model
	function automatic void predict(input logic [31:0] w, output logic ill,
		output logic wena, output logic [XLEN-1:0] res);
		logic [2:0] f3;
		logic [6:0] f7;
		logic [XLEN-1:0] imm;
		f3 = w[14:12];
		f7 = w[31:25];
		imm = XLEN'($signed(w[31:20]));
		ill = 1'b0;
		res = '0;
		case (w[6:0])
			OP_REG: begin
				ill = !(f7 == 7'b0 || (f7 == FUNCT7_ALT &&
					(f3 == F3_ADD_SUB || f3 == F3_SRL_SRA)));
				res = alu_calc(f3, f7 == FUNCT7_ALT, model[w[19:15]], model[w[24:20]]);
			end
			OP_IMM: begin
				if (f3 == F3_SLL)
					ill = w[31:26] != 6'b0 || (XLEN == 32 && w[25]);
				if (f3 == F3_SRL_SRA)
					ill = w[31] || w[29:26] != 4'b0 || (XLEN == 32 && w[25]);
				// no subtract in the immediate form
				res = alu_calc(f3, f3 == F3_SRL_SRA && w[30], model[w[19:15]], imm);
			end
			OP_LUI: res = XLEN'($signed({w[31:12], 12'b0}));
			default: ill = 1'b1;
		endcase
		wena = !ill && w[11:7] != 5'd0;
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				model[i] = '0;
			q_inst.delete();
			q_cycle.delete();
			cycle = 0;
			err_count = 0;
			miss_count = 0;
			retire_count = 0;
		end else begin
			cycle++;
			// anything older than two cycles never came out
			while (q_cycle.size() > 0 && q_cycle[0] + 2 < cycle) begin
				$display("retire missing for instruction %h accepted in cycle %0d",
					q_inst[0], q_cycle[0]);
				miss_count++;
				void'(q_inst.pop_front());
				void'(q_cycle.pop_front());
			end
			if ($isunknown(retire_valid)) begin
				$display("ERR %0t: retire_valid is unknown", $time);
				err_count++;
			end else if (retire_valid) begin
				retire_count++;
				if (q_inst.size() == 0) begin
					$display("ERR %0t: retire %h with no instruction accepted", $time, retire_inst);
					err_count++;
				end else begin
					head_inst = q_inst.pop_front();
					head_cycle = q_cycle.pop_front();
					predict(head_inst, exp_ill, exp_wena, exp_res);
					if (cycle - head_cycle != 2 || retire_inst !== head_inst) begin
						$display("ERR %0t: retired %h after %0d cycles, expected %h after 2",
							$time, retire_inst, cycle - head_cycle, head_inst);
						err_count++;
					end else if (retire_illegal !== exp_ill || retire_rd_wena !== exp_wena ||
						retire_rd_addr !== head_inst[11:7]) begin
						$display("ERR %0t: inst %h flags ill %b wena %b rd %0d, expected %b %b %0d",
							$time, head_inst, retire_illegal, retire_rd_wena, retire_rd_addr,
							exp_ill, exp_wena, head_inst[11:7]);
						err_count++;
					end else if (exp_wena && retire_rd_data !== exp_res) begin
						$display("ERR %0t: inst %h wrote %h, expected %h",
							$time, head_inst, retire_rd_data, exp_res);
						err_count++;
					end
					if (exp_wena)
						model[head_inst[11:7]] = exp_res;
				end
			end
			if (inst_valid) begin
				q_inst.push_back(inst);
				q_cycle.push_back(cycle);
			end
		end
		outstanding = q_inst.size();
	end

endmodule
